// File: logic/glcd_settings.svh
`ifndef GLCD_SETTINGS_SVH
`define GLCD_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// bus timing in clk cycles

`define GLCD_SETUP_CYCLES 2
`define GLCD_PULSE_CYCLES 4
`define GLCD_HOLD_CYCLES  2

// panel reset hold after our own reset is released
`define GLCD_RESET_CYCLES 16

// ~~~~~~~~~~~~~~~~~~~~
// KS0108 command bytes

`define GLCD_CMD_ON    8'h3F
`define GLCD_CMD_START 8'hC0
`define GLCD_CMD_COL0  8'h40
`define GLCD_CMD_PAGE  8'hB8

`endif

// File: logic/glcd_pkg.sv
`default_nettype none

package glcd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// panel geometry

	typedef logic [2:0]   pageT;     // 8 pages of 8 pixel rows
	typedef logic [6:0]   colT;      // bit 6 picks the chip
	typedef logic [7:0]   byteT;     // one column of one page
	typedef logic [255:0] chunkT;    // 32 columns, byte k at [8k+7:8k]
	typedef logic [1:0]   chipSelT;  // [0] left chip, [1] right chip

	// ~~~~~~~~~~~~~~~~~~~~
	// transfers between blocks

	typedef struct packed {
		logic    di;    // 1 data, 0 command
		chipSelT cs;
		byteT    data;
	} busCmdT;

	typedef struct packed {
		pageT page;
		colT  col;
		byteT data;
	} fbWriteT;

	typedef struct packed {
		pageT       page;
		logic [1:0] chunk;  // 32-column slice of the 128
	} chunkReqT;

	typedef enum logic [2:0] {
		resetHold,
		initCmd,
		clearPage,
		clearData,
		refreshPage,
		refreshData,
		frameEnd
	} seqStateT;

endpackage

`default_nettype wire

// File: logic/glcdFrameBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module glcdFrameBuffer (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     wrStrobe,
	input  wire glcd_pkg::fbWriteT  fbWrite,
	input  wire                     chunkStrobe,
	input  wire glcd_pkg::chunkReqT chunkReq,
	output glcd_pkg::chunkT         chunk,
	output logic                    chunkValid
);

	import glcd_pkg::*;

	localparam int unsigned chunksPerPage = 4;
	localparam int unsigned rowCount = 8 * chunksPerPage;  // 1024 bytes in 32 wide rows

	// memory is organized as one 256-bit row per page slice
	chunkT mem [0:rowCount-1];

	logic [4:0] wrRow;
	logic [7:0] wrBit;
	logic [4:0] rdRow;

	// ~~~~~~~~~~~~~~~~~~~~
	// host write port

	assign wrRow = {fbWrite.page, fbWrite.col[6:5]};
	assign wrBit = {fbWrite.col[4:0], 3'b000};  // byte lane inside the row

	always_ff @(posedge clk) begin
		if (wrStrobe) begin
			mem[wrRow][wrBit +: 8] <= fbWrite.data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// chunk read port, one cycle latency

	assign rdRow = {chunkReq.page, chunkReq.chunk};

	always_ff @(posedge clk) begin
		if (chunkStrobe) begin
			chunk <= mem[rdRow];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			chunkValid <= 1'b0;
		end else begin
			chunkValid <= chunkStrobe;
		end
	end

endmodule

`default_nettype wire

// File: logic/glcdBusDriver.sv
`timescale 1ns/1ps
`default_nettype none

`include "glcd_settings.svh"

module glcdBusDriver (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   busStrobe,
	input  wire glcd_pkg::busCmdT busCmd,
	output logic                  busDone,
	output glcd_pkg::byteT        lcdData,
	output logic                  lcdDi,
	output logic                  lcdCs1,
	output logic                  lcdCs2,
	output logic                  lcdEnable
);

	import glcd_pkg::*;

	localparam int unsigned totalCycles =
		`GLCD_SETUP_CYCLES + `GLCD_PULSE_CYCLES + `GLCD_HOLD_CYCLES;
	localparam int unsigned cntWidth = $clog2(totalCycles + 1);

	localparam logic [cntWidth-1:0] pulseFirst = cntWidth'(`GLCD_SETUP_CYCLES + 1);
	localparam logic [cntWidth-1:0] pulseLast =
		cntWidth'(`GLCD_SETUP_CYCLES + `GLCD_PULSE_CYCLES);
	localparam logic [cntWidth-1:0] lastPhase = cntWidth'(totalCycles);

	localparam chipSelT csIdle = 2'b11;

	logic [cntWidth-1:0] phaseCnt;  // cycle number since the strobe, 0 when idle
	logic [cntWidth-1:0] phaseNext;
	busCmdT              cmdQ;
	logic                enableQ;
	logic                doneQ;

	always_comb begin
		phaseNext = '0;
		if (busStrobe) begin
			phaseNext = cntWidth'(1);
		end else if (phaseCnt != '0 && phaseCnt != lastPhase) begin
			phaseNext = phaseCnt + cntWidth'(1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// phase counter and pin registers

	always_ff @(posedge clk) begin
		if (!reset) begin
			phaseCnt <= '0;
			enableQ <= 1'b0;
			doneQ <= 1'b0;
			cmdQ.di <= 1'b0;
			cmdQ.cs <= csIdle;
			cmdQ.data <= '0;
		end else begin
			phaseCnt <= phaseNext;
			enableQ <= (phaseNext >= pulseFirst) && (phaseNext <= pulseLast);
			doneQ <= (phaseNext == lastPhase);
			if (busStrobe) begin
				cmdQ <= busCmd;  // held through setup, pulse and hold
			end else if (phaseCnt == lastPhase) begin
				cmdQ.cs <= csIdle;  // enable is long low here
			end
		end
	end

	assign lcdData = cmdQ.data;
	assign lcdDi = cmdQ.di;
	assign lcdCs1 = cmdQ.cs[0];
	assign lcdCs2 = cmdQ.cs[1];
	assign lcdEnable = enableQ;
	assign busDone = doneQ;

endmodule

`default_nettype wire

// File: logic/glcdSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "glcd_settings.svh"

module glcdSequencer (
	input  wire                     clk,
	input  wire                     reset,
	output logic                    lcdRst,
	output logic                    chunkStrobe,
	output glcd_pkg::chunkReqT      chunkReq,
	input  wire                     chunkValid,
	input  wire glcd_pkg::chunkT    chunk,
	output logic                    busStrobe,
	output glcd_pkg::busCmdT        busCmd,
	input  wire                     busDone,
	output logic                    frameDone
);

	import glcd_pkg::*;

	localparam int unsigned rstWidth = $clog2(`GLCD_RESET_CYCLES);
	localparam logic [rstWidth-1:0] rstLast = rstWidth'(`GLCD_RESET_CYCLES - 1);

	localparam chipSelT csBoth = 2'b11;
	localparam chipSelT csLeft = 2'b01;
	localparam chipSelT csRight = 2'b10;

	seqStateT            state;
	logic [rstWidth-1:0] rstCnt;
	pageT                page;
	logic [5:0]          byteIdx;  // column within one chip
	logic                side;     // 0 left chip, 1 right chip
	logic                pending;  // transfer in flight on the bus

	chunkT      curChunk;   // bytes being sent
	chunkT      nextChunk;  // prefetched slice
	chunkT      srcChunk;
	byteT       dataByte;
	byteT       pageCmd;
	logic [1:0] chunkNum;
	logic       chunkFirst;
	logic       ready;
	logic       issue;
	logic       reqFire;
	chunkReqT   reqNext;
	busCmdT     txCmd;

	assign ready = !pending || busDone;
	assign issue = ready && (state inside {initCmd, clearPage, clearData, refreshPage, refreshData});

	// ~~~~~~~~~~~~~~~~~~~~
	// data path for refresh bytes

	assign chunkNum = {side, byteIdx[5]};
	assign chunkFirst = (byteIdx[4:0] == 5'd0);
	assign srcChunk = chunkFirst ? nextChunk : curChunk;  // first byte still in prefetch reg
	assign dataByte = srcChunk[{byteIdx[4:0], 3'b000} +: 8];
	assign pageCmd = `GLCD_CMD_PAGE | byteT'(page);

	always_comb begin
		reqFire = 1'b0;
		reqNext.page = page;
		reqNext.chunk = 2'd0;
		if (state == refreshPage) begin
			reqFire = issue;
		end else if (state == refreshData && chunkFirst && chunkNum != 2'd3) begin
			reqFire = issue;
			reqNext.chunk = chunkNum + 2'd1;  // fetch ahead while this slice goes out
		end
	end

	always_comb begin
		txCmd.di = 1'b0;
		txCmd.cs = csBoth;
		txCmd.data = pageCmd;
		case (state)
			initCmd: begin
				case (byteIdx[1:0])
					2'd0: txCmd.data = `GLCD_CMD_ON;
					2'd1: txCmd.data = `GLCD_CMD_START;
					default: txCmd.data = `GLCD_CMD_COL0;
				endcase
			end
			clearData: begin
				txCmd.di = 1'b1;
				txCmd.data = '0;
			end
			refreshData: begin
				txCmd.di = 1'b1;
				txCmd.cs = side ? csRight : csLeft;
				txCmd.data = dataByte;
			end
			default: ;  // page commands to both chips
		endcase
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			busCmd <= txCmd;
		end
		if (reqFire) begin
			chunkReq <= reqNext;
		end
		if (chunkValid) begin
			nextChunk <= chunk;
		end
		if (issue && state == refreshData && chunkFirst) begin
			curChunk <= nextChunk;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// FSM

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= resetHold;
			rstCnt <= '0;
			page <= '0;
			byteIdx <= '0;
			side <= 1'b0;
			pending <= 1'b0;
			lcdRst <= 1'b0;
			busStrobe <= 1'b0;
			chunkStrobe <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			busStrobe <= issue;
			chunkStrobe <= reqFire;
			frameDone <= 1'b0;
			if (issue) begin
				pending <= 1'b1;
			end else if (busDone) begin
				pending <= 1'b0;
			end
			case (state)
				resetHold: begin
					rstCnt <= rstCnt + rstWidth'(1);
					if (rstCnt == rstLast) begin
						lcdRst <= 1'b1;
						byteIdx <= '0;
						state <= initCmd;
					end
				end
				initCmd: begin
					if (issue) begin
						byteIdx <= byteIdx + 6'd1;
						if (byteIdx == 6'd2) begin
							page <= '0;
							state <= clearPage;
						end
					end
				end
				clearPage: begin
					if (issue) begin
						byteIdx <= '0;
						state <= clearData;
					end
				end
				clearData: begin
					if (issue) begin
						byteIdx <= byteIdx + 6'd1;  // wraps to 0 after 63
						if (byteIdx == 6'd63) begin
							page <= page + 3'd1;
							state <= (page == 3'd7) ? refreshPage : clearPage;
						end
					end
				end
				refreshPage: begin
					if (issue) begin
						byteIdx <= '0;
						side <= 1'b0;
						state <= refreshData;
					end
				end
				refreshData: begin
					if (issue) begin
						byteIdx <= byteIdx + 6'd1;
						if (byteIdx == 6'd63) begin
							side <= ~side;
							if (side) begin
								page <= page + 3'd1;
								state <= (page == 3'd7) ? frameEnd : refreshPage;
							end
						end
					end
				end
				frameEnd: begin
					if (ready) begin  // last byte of page 7 is out
						frameDone <= 1'b1;
						state <= refreshPage;
					end
				end
				default: state <= resetHold;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/glcdTop.sv
`timescale 1ns/1ps
`default_nettype none

module glcdTop (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    wrStrobe,
	input  wire glcd_pkg::fbWriteT fbWrite,
	output glcd_pkg::byteT         lcdData,
	output logic                   lcdDi,
	output logic                   lcdCs1,
	output logic                   lcdCs2,
	output logic                   lcdEnable,
	output logic                   lcdRst,
	output logic                   frameDone
);

	import glcd_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~
	// internal strobes and payloads

	chunkReqT chunkReq;
	logic     chunkStrobe;
	chunkT    chunk;
	logic     chunkValid;
	busCmdT   busCmd;
	logic     busStrobe;
	logic     busDone;

	glcdFrameBuffer u_frameBuffer (
		.clk         (clk),
		.reset       (reset),
		.wrStrobe    (wrStrobe),
		.fbWrite     (fbWrite),
		.chunkStrobe (chunkStrobe),
		.chunkReq    (chunkReq),
		.chunk       (chunk),
		.chunkValid  (chunkValid)
	);

	glcdSequencer u_sequencer (
		.clk         (clk),
		.reset       (reset),
		.lcdRst      (lcdRst),
		.chunkStrobe (chunkStrobe),
		.chunkReq    (chunkReq),
		.chunkValid  (chunkValid),
		.chunk       (chunk),
		.busStrobe   (busStrobe),
		.busCmd      (busCmd),
		.busDone     (busDone),
		.frameDone   (frameDone)
	);

	glcdBusDriver u_busDriver (
		.clk       (clk),
		.reset     (reset),
		.busStrobe (busStrobe),
		.busCmd    (busCmd),
		.busDone   (busDone),
		.lcdData   (lcdData),
		.lcdDi     (lcdDi),
		.lcdCs1    (lcdCs1),
		.lcdCs2    (lcdCs2),
		.lcdEnable (lcdEnable)
	);

endmodule

`default_nettype wire

// File: verif/glcdPanelModel.sv
`timescale 1ns/1ps
`default_nettype none

module glcdPanelModel (
	input  wire                 lcdEnable,
	input  wire glcd_pkg::byteT lcdData,
	input  wire                 lcdDi,
	input  wire                 lcdCs1,
	input  wire                 lcdCs2,
	input  wire                 lcdRst,
	output int                  cmdCount,
	output int                  dataCount,
	output int                  bothData,
	output int                  clearBytes,
	output int                  clearPageCmds,
	output logic                refreshSeen
);

	import glcd_pkg::*;

	byteT       chipMem [0:1023];  // {chip, page, col}
	pageT       pageReg [0:1];
	logic [5:0] colReg [0:1];
	byteT       cmdLogData [0:3];  // first commands after panel reset
	chipSelT    cmdLogCs [0:3];
	int         pageCmds;

	initial begin
		cmdCount = 0;
		dataCount = 0;
		bothData = 0;
		clearBytes = 0;
		clearPageCmds = 0;
		pageCmds = 0;
		refreshSeen = 1'b0;
		pageReg[0] = '0;
		pageReg[1] = '0;
		colReg[0] = '0;
		colReg[1] = '0;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// one transfer per falling edge of enable

	always @(negedge lcdEnable) begin
		chipSelT cs;
		int      chip;
		cs = {lcdCs2, lcdCs1};  // selects are active high here
		if (lcdRst === 1'b1) begin
			if (!lcdDi) begin
				if (cmdCount < 4) begin
					cmdLogData[cmdCount[1:0]] = lcdData;
					cmdLogCs[cmdCount[1:0]] = cs;
				end
				cmdCount++;
				if (lcdData[7:3] == 5'b10111) begin
					pageCmds++;
				end
				for (chip = 0; chip < 2; chip++) begin
					if (cs[chip[0]] && lcdData[7:3] == 5'b10111) begin
						pageReg[chip[0]] = lcdData[2:0];
					end else if (cs[chip[0]] && lcdData[7:6] == 2'b01) begin
						colReg[chip[0]] = lcdData[5:0];  // set address
					end
				end
			end else begin
				dataCount++;
				for (chip = 0; chip < 2; chip++) begin
					if (cs[chip[0]]) begin
						chipMem[{chip[0], pageReg[chip[0]], colReg[chip[0]]}] = lcdData;
						colReg[chip[0]] = colReg[chip[0]] + 6'd1;  // wraps at 64
					end
				end
				if (cs == 2'b11) begin
					bothData++;
					if (lcdData == '0) begin
						clearBytes++;
						clearPageCmds = pageCmds;
					end
				end else if (cs != 2'b00) begin
					refreshSeen = 1'b1;  // first single chip write
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/glcdTop_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "glcd_settings.svh"

module glcdTop_chk (
	input wire                 clk,
	input wire                 reset,
	input wire                 busStrobe,
	input wire                 busDone,
	input wire glcd_pkg::byteT lcdData,
	input wire                 lcdDi,
	input wire                 lcdCs1,
	input wire                 lcdCs2,
	input wire                 lcdEnable
);

	localparam int doneDelay = `GLCD_SETUP_CYCLES + `GLCD_PULSE_CYCLES + `GLCD_HOLD_CYCLES;

	logic [3:0] highCnt;  // cycles lcdEnable has been high

	always_ff @(posedge clk) begin
		if (!reset) begin
			highCnt <= '0;
		end else if (lcdEnable) begin
			highCnt <= highCnt + 4'd1;
		end else begin
			highCnt <= '0;
		end
	end

	pulseWidth: assert property (@(posedge clk) disable iff (!reset)
		$fell(lcdEnable) |-> highCnt == 4'(`GLCD_PULSE_CYCLES))
		else $error("lcdEnable pulse length is not %0d cycles", `GLCD_PULSE_CYCLES);

	pinsStable: assert property (@(posedge clk) disable iff (!reset)
		(lcdEnable || $past(lcdEnable)) |-> $stable({lcdData, lcdDi, lcdCs1, lcdCs2}))
		else $error("panel pins changed while lcdEnable was high");

	doneAfterStrobe: assert property (@(posedge clk) disable iff (!reset)
		$past(busStrobe, doneDelay) |-> busDone)
		else $error("busDone missing %0d cycles after busStrobe", doneDelay);

	doneOnlyAfterStrobe: assert property (@(posedge clk) disable iff (!reset)
		busDone |-> $past(busStrobe, doneDelay))
		else $error("busDone without a busStrobe %0d cycles before", doneDelay);

endmodule

`default_nettype wire

// File: verif/glcdTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "glcd_settings.svh"

module glcdTb;

	import glcd_pkg::*;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 8;
	localparam int testCount = 4;
	localparam int transferCycles =
		`GLCD_SETUP_CYCLES + `GLCD_PULSE_CYCLES + `GLCD_HOLD_CYCLES;
	localparam int frameCycles = (3 + `GLCD_RESET_CYCLES + 1040) * transferCycles;
	localparam int watchdogNs = testCount * 4 * (frameCycles + frameCycles / 4) * clkPeriod;

	logic    clk;
	logic    reset;
	logic    wrStrobe;
	fbWriteT fbWrite;
	byteT    lcdData;
	logic    lcdDi;
	logic    lcdCs1;
	logic    lcdCs2;
	logic    lcdEnable;
	logic    lcdRst;
	logic    frameDone;
	int      cmdCount;
	int      dataCount;
	int      bothData;
	int      clearBytes;
	int      clearPageCmds;
	logic    refreshSeen;

	byteT    expMem [0:1023];  // expected panel image by {page, col}
	fbWriteT writeTable [0:7];
	int      checks;
	int      errors;
	int      testsRun;
	int      testsFailed;
	int      testErrors;
	string   testName;

	always #(clkPeriod / 2) clk = ~clk;

	glcdTop u_dut (
		.clk       (clk),
		.reset     (reset),
		.wrStrobe  (wrStrobe),
		.fbWrite   (fbWrite),
		.lcdData   (lcdData),
		.lcdDi     (lcdDi),
		.lcdCs1    (lcdCs1),
		.lcdCs2    (lcdCs2),
		.lcdEnable (lcdEnable),
		.lcdRst    (lcdRst),
		.frameDone (frameDone)
	);

	glcdPanelModel u_panel (
		.lcdEnable     (lcdEnable),
		.lcdData       (lcdData),
		.lcdDi         (lcdDi),
		.lcdCs1        (lcdCs1),
		.lcdCs2        (lcdCs2),
		.lcdRst        (lcdRst),
		.cmdCount      (cmdCount),
		.dataCount     (dataCount),
		.bothData      (bothData),
		.clearBytes    (clearBytes),
		.clearPageCmds (clearPageCmds),
		.refreshSeen   (refreshSeen)
	);

	bind glcdBusDriver glcdTop_chk u_chk (
		.clk       (clk),
		.reset     (reset),
		.busStrobe (busStrobe),
		.busDone   (busDone),
		.lcdData   (lcdData),
		.lcdDi     (lcdDi),
		.lcdCs1    (lcdCs1),
		.lcdCs2    (lcdCs2),
		.lcdEnable (lcdEnable)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// compare and bookkeeping

	task automatic checkByte(input string name, input byteT expected, input byteT actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name,
				expected, actual);
		end
	endtask

	task automatic checkCount(input string name, input integer expected, input integer actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name,
				expected, actual);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = errors;
		testsRun++;
	endtask

	task automatic finishTest();
		if (errors != testErrors) begin
			testsFailed++;
			$display("test %s: failed with %0d errors", testName, errors - testErrors);
		end else begin
			$display("test %s: ok", testName);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// host side and frame helpers

	task automatic writeHost(input fbWriteT w);
		@(negedge clk);
		wrStrobe = 1'b1;
		fbWrite = w;
		expMem[{w.page, w.col}] = w.data;
	endtask

	task automatic endWrites();
		@(negedge clk);
		wrStrobe = 1'b0;
	endtask

	task automatic waitFrameDone();
		do begin
			@(negedge clk);
		end while (frameDone !== 1'b1);
	endtask

	task automatic compareFrame();
		int p;
		int c;
		for (p = 0; p < 8; p++) begin
			for (c = 0; c < 128; c++) begin  // col bit 6 picks the chip
				checkByte($sformatf("u_panel.chipMem chip %0d page %0d col %0d", c[6], p, c[5:0]),
					expMem[{pageT'(p), colT'(c)}], u_panel.chipMem[{c[6], pageT'(p), c[5:0]}]);
			end
		end
	endtask

	task automatic loadTable();
		writeTable[0] = '{3'd0, 7'd0, 8'hff};    // first column of the left chip
		writeTable[1] = '{3'd0, 7'd63, 8'h81};   // left chip edge
		writeTable[2] = '{3'd1, 7'd64, 8'h7e};   // right chip edge
		writeTable[3] = '{3'd3, 7'd31, 8'h3c};
		writeTable[4] = '{3'd3, 7'd32, 8'hc3};   // chunk boundary
		writeTable[5] = '{3'd5, 7'd96, 8'h55};
		writeTable[6] = '{3'd7, 7'd127, 8'haa};
		writeTable[7] = '{3'd0, 7'd0, 8'h18};    // overwrites entry 0
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// tests

	task automatic testResetInit();
		int lowCycles;
		int pulses;
		int i;
		byteT initCmds [0:2];
		initCmds[0] = `GLCD_CMD_ON;
		initCmds[1] = `GLCD_CMD_START;
		initCmds[2] = `GLCD_CMD_COL0;
		startTest("reset and init");
		checkCount("lcdRst in reset", 0, int'(lcdRst));
		checkCount("lcdEnable in reset", 0, int'(lcdEnable));
		checkCount("lcdCs1 in reset", 1, int'(lcdCs1));
		checkCount("lcdCs2 in reset", 1, int'(lcdCs2));
		checkCount("frameDone in reset", 0, int'(frameDone));
		reset = 1'b1;
		lowCycles = 0;
		pulses = 0;
		do begin
			@(negedge clk);
			lowCycles++;
			if (lcdEnable) begin
				pulses++;
			end
		end while (lcdRst !== 1'b1);
		checkCount("lcdRst low cycles", `GLCD_RESET_CYCLES, lowCycles);
		checkCount("lcdEnable cycles in panel reset", 0, pulses);
		while (cmdCount < 3) begin
			@(negedge clk);
		end
		checkCount("data transfers before init done", 0, dataCount);
		for (i = 0; i < 3; i++) begin
			checkByte($sformatf("init command %0d", i), initCmds[i[1:0]],
				u_panel.cmdLogData[i[1:0]]);
			checkCount($sformatf("init command %0d selects", i), 3,
				int'(u_panel.cmdLogCs[i[1:0]]));
		end
		finishTest();
	endtask

	task automatic fillBuffer();
		int p;
		int c;
		for (p = 0; p < 8; p++) begin
			for (c = 0; c < 128; c++) begin
				writeHost('{pageT'(p), colT'(c), byteT'($urandom)});
			end
		end
		endWrites();
	endtask

	task automatic testClear();
		startTest("clear");
		while (refreshSeen !== 1'b1) begin
			@(negedge clk);
		end
		checkCount("page commands during clear", 8, clearPageCmds);
		checkCount("zero bytes to both chips", 8 * 64, clearBytes);
		checkCount("data bytes to both chips", 8 * 64, bothData);
		finishTest();
	endtask

	task automatic testDirectedWrites();
		int i;
		startTest("directed writes");
		for (i = 0; i < 8; i++) begin
			writeHost(writeTable[i[2:0]]);
		end
		endWrites();
		waitFrameDone();
		waitFrameDone();  // the frame after the writes is the first clean one
		compareFrame();
		finishTest();
	endtask

	initial begin
		int seedValue;
		clk = 1'b0;
		reset = 1'b0;
		wrStrobe = 1'b0;
		fbWrite = '0;
		checks = 0;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		seedValue = 32'hcfcfd4e6;
		void'($urandom(seedValue));
		loadTable();
		repeat (resetCycles) @(negedge clk);
		testResetInit();
		fillBuffer();  // done long before the clear ends
		testClear();
		startTest("full frame");
		waitFrameDone();
		checkCount("command transfers at first frameDone", 3 + 8 + 8, cmdCount);
		checkCount("data transfers at first frameDone", 8 * 64 + 8 * 128, dataCount);
		compareFrame();
		finishTest();
		testDirectedWrites();
		$display("tests %0d, failed tests %0d, checks %0d, errors %0d (seed 0x%08h)",
			testsRun, testsFailed, checks, errors, seedValue);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("timeout after %0d ns: frameDone never arrived", watchdogNs);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: glcdTop.f
+incdir+logic
logic/glcd_pkg.sv
logic/glcdFrameBuffer.sv
logic/glcdBusDriver.sv
logic/glcdSequencer.sv
logic/glcdTop.sv
verif/glcdPanelModel.sv
verif/glcdTop_chk.sv
verif/glcdTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module glcdTb -f glcdTop.f -o glcdSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/glcdSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Regression passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
